// ==== hw/isa_pkg.sv ====
package isa_pkg;

    // datapath and instruction word widths
    localparam int xlen = 32;
    localparam int ilen = 32;
    localparam int reg_field_w = 8;
    localparam int imm_w = 16;

    // only eight codes are legal, anything else gets dropped in decode
    typedef enum logic [3:0] {
        op_and  = 4'd0,
        op_or   = 4'd1,
        op_xor  = 4'd2,
        op_nor  = 4'd3,
        op_add  = 4'd8,
        op_sub  = 4'd9,
        op_slt  = 4'd10,
        op_sltu = 4'd11
    } opcode_t;

    typedef enum logic {
        cls_logic = 1'b0,
        cls_arith = 1'b1
    } op_class_t;

    // register form, second operand from src_b
    typedef struct packed {
        opcode_t                  opcode;
        logic                     fmt;
        logic [reg_field_w-1:0]   dst;
        logic [18:0]              rsvd;
    } instr_r_t;

    // immediate form, second operand is the sign-extended imm
    typedef struct packed {
        opcode_t                  opcode;
        logic                     fmt;
        logic [reg_field_w-1:0]   dst;
        logic [2:0]               spare;
        logic [imm_w-1:0]         imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

// ==== hw/wb_pkg.sv ====
package wb_pkg;

    // physical register index width
    localparam int preg_w = 8;

    // one ring slot, valid on top so an all-zero entry is empty
    typedef struct packed {
        logic                     valid;
        logic [preg_w-1:0]        dst;
        logic [isa_pkg::xlen-1:0] value;
    } ring_entry_t;

    // a slot with nothing in it
    localparam ring_entry_t empty_entry = '0;

endpackage

// ==== hw/fu_issue_if.sv ====
`timescale 1ns/10ps

interface fu_issue_if;

    logic                       valid;
    isa_pkg::op_class_t         op_class;
    isa_pkg::opcode_t           opcode;
    logic [isa_pkg::xlen-1:0]   operand_a;
    logic [isa_pkg::xlen-1:0]   operand_b;
    logic [wb_pkg::preg_w-1:0]  dst;
    // single-cycle accept from the target unit
    logic                       take;

    modport decode (
        output valid,
        output op_class,
        output opcode,
        output operand_a,
        output operand_b,
        output dst,
        input  take
    );

    modport execute (
        input  valid,
        input  op_class,
        input  opcode,
        input  operand_a,
        input  operand_b,
        input  dst,
        output take
    );

endinterface

// ==== hw/fu_result_if.sv ====
`timescale 1ns/10ps

interface fu_result_if;

    logic                       valid;
    logic [wb_pkg::preg_w-1:0]  dst;
    logic [isa_pkg::xlen-1:0]   value;
    // high in the cycle the ring has room at this unit's point
    logic                       inserted;

    modport unit (
        output valid,
        output dst,
        output value,
        input  inserted
    );

    modport ring (
        input  valid,
        input  dst,
        input  value,
        output inserted
    );

endinterface

// ==== hw/op_decoder.sv ====
`timescale 1ns/10ps

module op_decoder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue,
    input  isa_pkg::instr_u           instr,
    input  logic [isa_pkg::xlen-1:0]  src_a,
    input  logic [isa_pkg::xlen-1:0]  src_b,
    output logic                      busy,
    fu_issue_if.decode                iss
);

    logic                      held;
    logic                      accept;
    logic                      legal;
    isa_pkg::instr_u           instr_q;
    logic [isa_pkg::xlen-1:0]  a_q;
    logic [isa_pkg::xlen-1:0]  b_q;
    logic [isa_pkg::xlen-1:0]  imm_ext;

    // a new issue may land on the same edge the old op is taken
    assign accept = issue & ~busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held <= 1'b0;
        end else if (accept) begin
            held <= 1'b1;
        end else if (iss.take || !legal) begin
            // taken by a unit, or an illegal op that just falls away
            held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr;
            a_q     <= src_a;
            b_q     <= src_b;
        end
    end

    always_comb begin
        case (instr_q.r.opcode)
            isa_pkg::op_and,
            isa_pkg::op_or,
            isa_pkg::op_xor,
            isa_pkg::op_nor,
            isa_pkg::op_add,
            isa_pkg::op_sub,
            isa_pkg::op_slt,
            isa_pkg::op_sltu: legal = 1'b1;
            default:          legal = 1'b0;
        endcase
    end

    // immediate view of the same word
    assign imm_ext = {{(isa_pkg::xlen - isa_pkg::imm_w){instr_q.i.imm[isa_pkg::imm_w-1]}},
                      instr_q.i.imm};

    assign iss.valid     = held & legal;
    assign iss.opcode    = instr_q.r.opcode;
    // top bit of the opcode splits the two classes
    assign iss.op_class  = instr_q.r.opcode[3] ? isa_pkg::cls_arith : isa_pkg::cls_logic;
    assign iss.operand_a = a_q;
    assign iss.operand_b = instr_q.r.fmt ? imm_ext : b_q;
    assign iss.dst       = instr_q.r.dst;

    assign busy = iss.valid & ~iss.take;

endmodule

// ==== hw/exec_units.sv ====
`timescale 1ns/10ps

module exec_units (
    input  logic          clk,
    input  logic          rst,
    fu_issue_if.execute   iss,
    fu_result_if.unit     logic_res,
    fu_result_if.unit     arith_res
);

    logic                       take_logic;
    logic                       take_arith;
    logic [isa_pkg::xlen-1:0]   logic_val;
    logic [isa_pkg::xlen-1:0]   arith_val;

    logic                       l_valid;
    logic [wb_pkg::preg_w-1:0]  l_dst;
    logic [isa_pkg::xlen-1:0]   l_value;
    logic                       a_valid;
    logic [wb_pkg::preg_w-1:0]  a_dst;
    logic [isa_pkg::xlen-1:0]   a_value;

    // a unit accepts when its result register is free or leaving this cycle
    assign take_logic = iss.valid && iss.op_class == isa_pkg::cls_logic &&
                        (!l_valid || logic_res.inserted);
    assign take_arith = iss.valid && iss.op_class == isa_pkg::cls_arith &&
                        (!a_valid || arith_res.inserted);
    assign iss.take   = take_logic | take_arith;

    // logical lane
    always_comb begin
        case (iss.opcode)
            isa_pkg::op_and: logic_val = iss.operand_a & iss.operand_b;
            isa_pkg::op_or:  logic_val = iss.operand_a | iss.operand_b;
            isa_pkg::op_xor: logic_val = iss.operand_a ^ iss.operand_b;
            isa_pkg::op_nor: logic_val = ~(iss.operand_a | iss.operand_b);
            default:         logic_val = '0;
        endcase
    end

    // arithmetic lane, compares give 1 or 0
    always_comb begin
        case (iss.opcode)
            isa_pkg::op_add:  arith_val = iss.operand_a + iss.operand_b;
            isa_pkg::op_sub:  arith_val = iss.operand_a - iss.operand_b;
            isa_pkg::op_slt:  arith_val = isa_pkg::xlen'($signed(iss.operand_a) <
                                                         $signed(iss.operand_b));
            isa_pkg::op_sltu: arith_val = isa_pkg::xlen'(iss.operand_a < iss.operand_b);
            default:          arith_val = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            l_valid <= 1'b0;
            a_valid <= 1'b0;
        end else begin
            if (take_logic) begin
                l_valid <= 1'b1;
            end else if (logic_res.inserted) begin
                l_valid <= 1'b0;
            end
            if (take_arith) begin
                a_valid <= 1'b1;
            end else if (arith_res.inserted) begin
                a_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_logic) begin
            l_dst   <= iss.dst;
            l_value <= logic_val;
        end
        if (take_arith) begin
            a_dst   <= iss.dst;
            a_value <= arith_val;
        end
    end

    assign logic_res.valid = l_valid;
    assign logic_res.dst   = l_dst;
    assign logic_res.value = l_value;
    assign arith_res.valid = a_valid;
    assign arith_res.dst   = a_dst;
    assign arith_res.value = a_value;

endmodule

// ==== hw/result_ring.sv ====
`timescale 1ns/10ps

module result_ring #(
    parameter int ring_slots = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    fu_result_if.ring                  logic_res,
    fu_result_if.ring                  arith_res,
    input  logic                       rf_hold,
    output logic                       wb_valid,
    output logic [wb_pkg::preg_w-1:0]  wb_reg,
    output logic [isa_pkg::xlen-1:0]   wb_val
);

    // slot 0 is the ring's end, slot ring_slots-1 its top
    wb_pkg::ring_entry_t slot [ring_slots];

    wb_pkg::ring_entry_t top_in;
    wb_pkg::ring_entry_t next_top;
    wb_pkg::ring_entry_t next_sub;
    logic                drain;

    // slot 0 goes out when the port is free, otherwise wraps to the top
    assign drain  = slot[0].valid & ~rf_hold;
    assign top_in = rf_hold ? slot[0] : wb_pkg::empty_entry;

    // logical unit sees the entry heading into the top slot
    assign logic_res.inserted = logic_res.valid & ~top_in.valid;
    // arithmetic unit sees the one heading into the slot below
    assign arith_res.inserted = arith_res.valid & ~slot[ring_slots-1].valid;

    always_comb begin
        next_top = top_in;
        if (logic_res.inserted) begin
            next_top.valid = 1'b1;
            next_top.dst   = logic_res.dst;
            next_top.value = logic_res.value;
        end
    end

    always_comb begin
        next_sub = slot[ring_slots-1];
        if (arith_res.inserted) begin
            next_sub.valid = 1'b1;
            next_sub.dst   = arith_res.dst;
            next_sub.value = arith_res.value;
        end
    end

    // rotate one position toward slot 0 on every edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ring_slots; i++) begin
                slot[i] <= wb_pkg::empty_entry;
            end
        end else begin
            for (int i = 0; i < ring_slots - 2; i++) begin
                slot[i] <= slot[i+1];
            end
            slot[ring_slots-2] <= next_sub;
            slot[ring_slots-1] <= next_top;
        end
    end

    // registered writeback port
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= drain;
        end
    end

    always_ff @(posedge clk) begin
        if (drain) begin
            wb_reg <= slot[0].dst;
            wb_val <= slot[0].value;
        end
    end

endmodule

// ==== hw/exec_cluster.sv ====
`timescale 1ns/10ps

module exec_cluster #(
    parameter int ring_slots = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       issue,
    input  logic [isa_pkg::ilen-1:0]   instr,
    input  logic [isa_pkg::xlen-1:0]   src_a,
    input  logic [isa_pkg::xlen-1:0]   src_b,
    input  logic                       rf_hold,
    output logic                       busy,
    output logic                       wb_valid,
    output logic [wb_pkg::preg_w-1:0]  wb_reg,
    output logic [isa_pkg::xlen-1:0]   wb_val
);

    // decoder to units
    fu_issue_if  iss_bus ();
    // one result channel per unit into the ring
    fu_result_if logic_bus ();
    fu_result_if arith_bus ();

    op_decoder u_decoder (
        .clk   (clk),
        .rst   (rst),
        .issue (issue),
        .instr (instr),
        .src_a (src_a),
        .src_b (src_b),
        .busy  (busy),
        .iss   (iss_bus.decode)
    );

    exec_units u_units (
        .clk       (clk),
        .rst       (rst),
        .iss       (iss_bus.execute),
        .logic_res (logic_bus.unit),
        .arith_res (arith_bus.unit)
    );

    result_ring #(
        .ring_slots (ring_slots)
    ) u_ring (
        .clk       (clk),
        .rst       (rst),
        .logic_res (logic_bus.ring),
        .arith_res (arith_bus.ring),
        .rf_hold   (rf_hold),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_val    (wb_val)
    );

endmodule

// ==== tests/tb_model.svh ====
`ifndef tb_model_svh
`define tb_model_svh

// xorshift state starting from the fixed seed
logic [31:0] rng_state = 32'd7;

// expected value per destination register, and which ones are still in flight
logic [31:0] expected_val [256];
bit          outstanding [256];
int          pending = 0;

function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// opcode, format bit, destination, then the low 19 bits
function automatic logic [31:0] encode_instr(input logic [3:0] op, input logic fmt,
                                             input logic [7:0] dst, input logic [15:0] imm);
    if (fmt) begin
        return {op, 1'b1, dst, 3'b000, imm};
    end
    return {op, 1'b0, dst, 19'd0};
endfunction

function automatic bit is_legal(input logic [3:0] op);
    return (op <= 4'd3) || (op >= 4'd8 && op <= 4'd11);
endfunction

function automatic logic [31:0] expected_result(input logic [3:0] op, input logic fmt,
                                                input logic [15:0] imm,
                                                input logic [31:0] a, input logic [31:0] b);
    logic [31:0] second;
    // immediate form replaces src_b with the sign-extended immediate
    second = fmt ? {{16{imm[15]}}, imm} : b;
    case (op)
        4'd0:    return a & second;
        4'd1:    return a | second;
        4'd2:    return a ^ second;
        4'd3:    return ~(a | second);
        4'd8:    return a + second;
        4'd9:    return a - second;
        4'd10:   return ($signed(a) < $signed(second)) ? 32'd1 : 32'd0;
        4'd11:   return (a < second) ? 32'd1 : 32'd0;
        default: return 32'd0;
    endcase
endfunction

// next register with nothing in flight
function automatic logic [7:0] pick_free_reg();
    logic [7:0] r;
    int         tries;
    r = 8'(xorshift32());
    tries = 0;
    // one pass over the whole register space at most
    while (outstanding[r] && tries < 256) begin
        r = r + 8'd1;
        tries++;
    end
    return r;
endfunction

`endif

// ==== tests/tb_exec_cluster.sv ====
`timescale 1ns/10ps

module tb_exec_cluster;

    localparam int half_period = 20;
    localparam int ring_slots  = 4;
    localparam int wait_limit  = 200;

    logic        clk;
    logic        rst;
    logic        issue;
    logic [31:0] instr;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic        rf_hold;
    logic        busy;
    logic        wb_valid;
    logic [7:0]  wb_reg;
    logic [31:0] wb_val;

    int errors = 0;
    int test_start = 0;
    int tests_run = 0;
    int accepted_legal = 0;
    int wb_count = 0;
    bit last_accepted;

    `include "tb_model.svh"

    exec_cluster #(.ring_slots(ring_slots)) UUT (
        .clk(clk), .rst(rst), .issue(issue), .instr(instr), .src_a(src_a), .src_b(src_b),
        .rf_hold(rf_hold), .busy(busy), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_val(wb_val)
    );

    always #(half_period) clk = ~clk;

    task automatic check_outputs(input logic hold_prev);
        assert (!(hold_prev && wb_valid)) else begin
            $display("wb_valid went high right after an edge with rf_hold high");
            errors++;
        end
        if (wb_valid) begin
            wb_count++;
            assert (outstanding[wb_reg]) else begin
                $display("writeback to register %h which has no result outstanding", wb_reg);
                errors++;
            end
            if (outstanding[wb_reg]) begin
                assert (wb_val === expected_val[wb_reg]) else begin
                    $display("mismatch wb_val reg %h: got %h expected %h",
                             wb_reg, wb_val, expected_val[wb_reg]);
                    errors++;
                end
                outstanding[wb_reg] = 1'b0;
                pending--;
            end
        end
    endtask

    // drive on the falling edge, sample halfway to the rising edge
    task automatic run_cycle(input logic do_issue, input logic [3:0] op, input logic fmt,
                             input logic [15:0] imm, input logic [31:0] a,
                             input logic [31:0] b, input logic hold);
        logic       hold_prev;
        logic [7:0] dst;
        @(negedge clk);
        hold_prev = rf_hold;
        dst       = pick_free_reg();
        issue     = do_issue;
        instr     = encode_instr(op, fmt, dst, imm);
        src_a     = a;
        src_b     = b;
        rf_hold   = hold;
        #(half_period / 2);
        check_outputs(hold_prev);
        last_accepted = do_issue && !busy;
        if (last_accepted && is_legal(op)) begin
            expected_val[dst] = expected_result(op, fmt, imm, a, b);
            outstanding[dst]  = 1'b1;
            pending++;
            accepted_legal++;
        end
    endtask

    // mode 0 logical, 1 arithmetic, 2 mixed, 3 mixed with illegal codes
    task automatic random_cycle(input int mode, input int hold_pct);
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        logic [3:0]  op;
        r   = xorshift32();
        a   = xorshift32();
        b   = xorshift32();
        imm = 16'(xorshift32());
        op  = {(mode == 0) ? 1'b0 : (mode == 1) ? 1'b1 : r[3], 1'b0, r[1:0]};
        if (mode == 3 && r[15:8] % 10 == 0) begin
            // codes 4-7 and 12-15
            op[2] = 1'b1;
        end
        run_cycle(r[31:24] % 10 < 6, op, r[2], imm, a, b, r[23:16] % 100 < hold_pct);
    endtask

    task automatic issue_until_taken(input logic [3:0] op, input logic fmt,
                                     input logic [15:0] imm, input logic [31:0] a,
                                     input logic [31:0] b);
        int tries;
        tries = 0;
        last_accepted = 1'b0;
        while (!last_accepted && tries < wait_limit) begin
            run_cycle(1'b1, op, fmt, imm, a, b, 1'b0);
            tries++;
        end
        assert (last_accepted) else begin
            $display("issue of opcode %h was never accepted, busy stayed high", op);
            errors++;
        end
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (pending != 0 && waited < wait_limit) begin
            run_cycle(1'b0, 4'd0, 1'b0, 16'd0, 32'd0, 32'd0, 1'b0);
            waited++;
        end
        assert (pending == 0) else begin
            $display("timed out draining, %0d results still outstanding", pending);
            errors++;
        end
        // window to catch stray or duplicate writebacks
        repeat (2 * (ring_slots + 3)) run_cycle(1'b0, 4'd0, 1'b0, 16'd0, 32'd0, 32'd0, 1'b0);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_start) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - test_start);
        end
        test_start = errors;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        issue = 1'b0;
        instr = '0;
        src_a = '0;
        src_b = '0;
        rf_hold = 1'b0;
        repeat (15) begin
            @(negedge clk);
            #(half_period / 2);
            assert (!busy && !wb_valid) else begin
                $display("mismatch busy %h wb_valid %h during reset, expected 0", busy, wb_valid);
                errors++;
            end
        end
        @(negedge clk);
        rst = 1'b0;
        run_cycle(1'b0, 4'd0, 1'b0, 16'd0, 32'd0, 32'd0, 1'b0);
        assert (!busy && !wb_valid) else begin
            $display("mismatch busy %h wb_valid %h after reset, expected 0", busy, wb_valid);
            errors++;
        end
        finish_test("reset");

        repeat (150) random_cycle(0, 0);
        drain_results();
        finish_test("logical ops");

        // subtract wrap, signed against unsigned compare, negative immediate
        issue_until_taken(4'd9, 1'b0, 16'd0, 32'd0, 32'd1);
        issue_until_taken(4'd10, 1'b0, 16'd0, 32'hffff_ffff, 32'd1);
        issue_until_taken(4'd11, 1'b0, 16'd0, 32'hffff_ffff, 32'd1);
        issue_until_taken(4'd8, 1'b1, 16'h8000, 32'd5, 32'd0);
        repeat (150) random_cycle(1, 0);
        drain_results();
        finish_test("arithmetic ops");

        repeat (300) random_cycle(2, 25);
        drain_results();
        finish_test("random rf_hold");

        repeat (300) random_cycle(3, 25);
        drain_results();
        finish_test("illegal and busy issues");

        repeat (200) random_cycle(3, 25);
        drain_results();
        assert (wb_count == accepted_legal) else begin
            $display("%0d writebacks seen for %0d accepted legal issues", wb_count, accepted_legal);
            errors++;
        end
        finish_test("final drain");

        $display("tests %0d, writebacks %0d, errors %0d", tests_run, wb_count, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+tests
hw/isa_pkg.sv
hw/wb_pkg.sv
hw/fu_issue_if.sv
hw/fu_result_if.sv
hw/op_decoder.sv
hw/exec_units.sv
hw/result_ring.sv
hw/exec_cluster.sv
tests/tb_exec_cluster.sv
